//--- logic/isa_pkg.sv
package isa_pkg;

    // major opcode values, bits 31:26
    localparam logic [5:0] OPCODE_SPECIAL = 6'h00;
    localparam logic [5:0] OPCODE_ADDIU   = 6'h09;
    localparam logic [5:0] OPCODE_SLTI    = 6'h0a;
    localparam logic [5:0] OPCODE_SLTIU   = 6'h0b;
    localparam logic [5:0] OPCODE_ANDI    = 6'h0c;
    localparam logic [5:0] OPCODE_ORI     = 6'h0d;
    localparam logic [5:0] OPCODE_XORI    = 6'h0e;
    localparam logic [5:0] OPCODE_LUI     = 6'h0f;

    // function field under SPECIAL
    localparam logic [5:0] FUNC_SLL  = 6'h00;
    localparam logic [5:0] FUNC_SRL  = 6'h02;
    localparam logic [5:0] FUNC_SRA  = 6'h03;
    localparam logic [5:0] FUNC_ADDU = 6'h21;
    localparam logic [5:0] FUNC_SUBU = 6'h23;
    localparam logic [5:0] FUNC_AND  = 6'h24;
    localparam logic [5:0] FUNC_OR   = 6'h25;
    localparam logic [5:0] FUNC_XOR  = 6'h26;
    localparam logic [5:0] FUNC_NOR  = 6'h27;
    localparam logic [5:0] FUNC_SLT  = 6'h2a;
    localparam logic [5:0] FUNC_SLTU = 6'h2b;

    // low bit of each instruction field
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_LSB  = 6;
    localparam int FUNC_LSB   = 0;
    localparam int IMM_LSB    = 0;

    // register file geometry
    localparam int REG_COUNT          = 32;
    localparam int LINK_FREE_ZERO_REG = 0;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;

    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t;

    // alu operations carried from ID to EX
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

endpackage

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t r_addr1,
    input  reg_addr_t r_addr2,
    input  logic      w_enable,
    input  reg_addr_t w_addr,
    input  word_t     w_data,
    output word_t     r_data1,
    output word_t     r_data2
);

    localparam reg_addr_t ZERO_REG = reg_addr_t'(LINK_FREE_ZERO_REG);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (w_enable && w_addr != ZERO_REG) begin
            regs[w_addr] <= w_data;
        end
    end

    // asynchronous reads, zero register hardwired
    assign r_data1 = (r_addr1 == ZERO_REG) ? '0 : regs[r_addr1];
    assign r_data2 = (r_addr2 == ZERO_REG) ? '0 : regs[r_addr2];

endmodule

//--- logic/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      ex_wen,
    input  reg_addr_t ex_wnum,
    input  word_t     ex_result,
    input  logic      wb_wen,
    input  reg_addr_t wb_wnum,
    input  word_t     wb_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    localparam reg_addr_t ZERO_REG = reg_addr_t'(LINK_FREE_ZERO_REG);

    word_t rf_rs_data;
    word_t rf_rt_data;

    // youngest producer wins: EX, then WB, then the file
    function automatic word_t pick_operand(
        input reg_addr_t addr,
        input word_t     rf_data,
        input logic      ex_hit_en,
        input reg_addr_t ex_num,
        input word_t     ex_data,
        input logic      wb_hit_en,
        input reg_addr_t wb_num,
        input word_t     wb_value
    );
        if (addr == ZERO_REG) begin
            return rf_data;
        end else if (ex_hit_en && ex_num == addr) begin
            return ex_data;
        end else if (wb_hit_en && wb_num == addr) begin
            return wb_value;
        end
        return rf_data;
    endfunction

    assign rs_data = pick_operand(rs_addr, rf_rs_data, ex_wen, ex_wnum, ex_result,
                                  wb_wen, wb_wnum, wb_data);
    assign rt_data = pick_operand(rt_addr, rf_rt_data, ex_wen, ex_wnum, ex_result,
                                  wb_wen, wb_wnum, wb_data);

    register_file i_register_file (
        .clk      (clk),
        .r_addr1  (rs_addr),
        .r_addr2  (rt_addr),
        .w_enable (wb_wen),
        .w_addr   (wb_wnum),
        .w_data   (wb_data),
        .r_data1  (rf_rs_data),
        .r_data2  (rf_rt_data)
    );

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hbfc00000
) (
    input  logic  clk,
    input  logic  reset,
    output logic  inst_sram_en,
    output word_t inst_sram_addr,
    output word_t pc_if,
    output logic  valid_if
);

    logic start;

    // sram is always read, one word per cycle
    assign inst_sram_en = 1'b1;

    // restart from RESET_PC until the first word is in IF
    assign inst_sram_addr = valid_if ? pc_if + 32'd4 : RESET_PC;

    always_ff @(posedge clk) begin
        if (reset) begin
            start    <= 1'b0;
            valid_if <= 1'b0;
        end else begin
            start    <= 1'b1;
            valid_if <= start;
        end
    end

    // pc of the word the sram returns next cycle
    always_ff @(posedge clk) begin
        pc_if <= inst_sram_addr;
    end

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  word_t     pc_if,
    input  logic      valid_if,
    input  word_t     instruction,
    input  word_t     rs_data,
    input  word_t     rt_data,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output logic      ex_valid,
    output word_t     ex_pc,
    output alu_op_t   ex_op,
    output word_t     ex_a,
    output word_t     ex_b,
    output logic      ex_wen,
    output reg_addr_t ex_wnum
);

    localparam reg_addr_t ZERO_REG = reg_addr_t'(LINK_FREE_ZERO_REG);

    logic  id_valid;
    word_t id_pc;
    word_t id_inst;

    logic [5:0]  opcode;
    logic [5:0]  func;
    reg_addr_t   rd_addr;
    logic [4:0]  shamt;
    logic [15:0] imm;

    alu_op_t   op;
    logic      known;
    logic      dest_is_rd;
    logic      a_is_shamt;
    logic      b_is_imm;
    logic      imm_signed;
    reg_addr_t wnum;
    word_t     imm_ext;
    word_t     op_a;
    word_t     op_b;

    // IF/ID
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= valid_if;
        end
    end

    always_ff @(posedge clk) begin
        id_pc   <= pc_if;
        id_inst <= instruction;
    end

    assign opcode  = id_inst[OPCODE_LSB +: 6];
    assign rs_addr = id_inst[RS_LSB +: 5];
    assign rt_addr = id_inst[RT_LSB +: 5];
    assign rd_addr = id_inst[RD_LSB +: 5];
    assign shamt   = id_inst[SHAMT_LSB +: 5];
    assign func    = id_inst[FUNC_LSB +: 6];
    assign imm     = id_inst[IMM_LSB +: 16];

    always_comb begin
        op         = ALU_ADD;
        known      = 1'b1;
        dest_is_rd = 1'b0;
        a_is_shamt = 1'b0;
        b_is_imm   = 1'b0;
        imm_signed = 1'b0;
        if (opcode == OPCODE_SPECIAL) begin
            dest_is_rd = 1'b1;
            case (func)
                FUNC_ADDU: op = ALU_ADD;
                FUNC_SUBU: op = ALU_SUB;
                FUNC_AND:  op = ALU_AND;
                FUNC_OR:   op = ALU_OR;
                FUNC_XOR:  op = ALU_XOR;
                FUNC_NOR:  op = ALU_NOR;
                FUNC_SLT:  op = ALU_SLT;
                FUNC_SLTU: op = ALU_SLTU;
                FUNC_SLL: begin
                    op         = ALU_SLL;
                    a_is_shamt = 1'b1;
                end
                FUNC_SRL: begin
                    op         = ALU_SRL;
                    a_is_shamt = 1'b1;
                end
                FUNC_SRA: begin
                    op         = ALU_SRA;
                    a_is_shamt = 1'b1;
                end
                default: known = 1'b0;
            endcase
        end else begin
            b_is_imm = 1'b1;
            case (opcode)
                OPCODE_ADDIU: begin
                    op         = ALU_ADD;
                    imm_signed = 1'b1;
                end
                OPCODE_SLTI: begin
                    op         = ALU_SLT;
                    imm_signed = 1'b1;
                end
                OPCODE_SLTIU: begin
                    op         = ALU_SLTU;
                    imm_signed = 1'b1;
                end
                OPCODE_ANDI: op = ALU_AND;
                OPCODE_ORI:  op = ALU_OR;
                OPCODE_XORI: op = ALU_XOR;
                OPCODE_LUI:  op = ALU_LUI;
                default: known = 1'b0;
            endcase
        end
    end

    assign wnum    = dest_is_rd ? rd_addr : rt_addr;
    assign imm_ext = imm_signed ? {{16{imm[15]}}, imm} : {16'b0, imm};
    assign op_a    = a_is_shamt ? {27'b0, shamt} : rs_data;
    assign op_b    = b_is_imm ? imm_ext : rt_data;

    // ID/EX
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_wen   <= 1'b0;
        end else begin
            ex_valid <= id_valid;
            ex_wen   <= id_valid && known && (wnum != ZERO_REG);
        end
    end

    always_ff @(posedge clk) begin
        ex_pc   <= id_pc;
        ex_op   <= op;
        ex_a    <= op_a;
        ex_b    <= op_b;
        ex_wnum <= wnum;
    end

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_valid,
    input  word_t     ex_pc,
    input  alu_op_t   ex_op,
    input  word_t     ex_a,
    input  word_t     ex_b,
    input  logic      ex_wen,
    input  reg_addr_t ex_wnum,
    output word_t     ex_result,
    output word_t     wb_pc,
    output logic      wb_wen,
    output reg_addr_t wb_wnum,
    output word_t     wb_data
);

    logic [4:0] sa;

    // shift amount from the low bits of A
    assign sa = ex_a[4:0];

    always_comb begin
        case (ex_op)
            ALU_ADD:  ex_result = ex_a + ex_b;
            ALU_SUB:  ex_result = ex_a - ex_b;
            ALU_AND:  ex_result = ex_a & ex_b;
            ALU_OR:   ex_result = ex_a | ex_b;
            ALU_XOR:  ex_result = ex_a ^ ex_b;
            ALU_NOR:  ex_result = ~(ex_a | ex_b);
            ALU_SLT:  ex_result = {31'b0, $signed(ex_a) < $signed(ex_b)};
            ALU_SLTU: ex_result = {31'b0, ex_a < ex_b};
            ALU_SLL:  ex_result = ex_b << sa;
            ALU_SRL:  ex_result = ex_b >> sa;
            ALU_SRA:  ex_result = $signed(ex_b) >>> sa;
            ALU_LUI:  ex_result = ex_b << 16;
            default:  ex_result = '0;
        endcase
    end

    // EX/WB
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_wen <= 1'b0;
        end else begin
            wb_wen <= ex_valid && ex_wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc   <= ex_pc;
        wb_wnum <= ex_wnum;
        wb_data <= ex_result;
    end

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hbfc00000
) (
    input  logic       clk,
    input  logic       reset,
    input  word_t      inst_sram_rdata,
    output logic       inst_sram_en,
    output word_t      inst_sram_addr,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    word_t     pc_if;
    logic      valid_if;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    logic      ex_valid;
    word_t     ex_pc;
    alu_op_t   ex_op;
    word_t     ex_a;
    word_t     ex_b;
    logic      ex_wen;
    reg_addr_t ex_wnum;
    word_t     ex_result;

    logic      wb_wen;
    reg_addr_t wb_wnum;
    word_t     wb_data;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) i_fetch_unit (
        .clk            (clk),
        .reset          (reset),
        .inst_sram_en   (inst_sram_en),
        .inst_sram_addr (inst_sram_addr),
        .pc_if          (pc_if),
        .valid_if       (valid_if)
    );

    decode_unit i_decode_unit (
        .clk         (clk),
        .reset       (reset),
        .pc_if       (pc_if),
        .valid_if    (valid_if),
        .instruction (inst_sram_rdata),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_op       (ex_op),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_wen      (ex_wen),
        .ex_wnum     (ex_wnum)
    );

    operand_bypass i_operand_bypass (
        .clk       (clk),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .ex_wen    (ex_wen),
        .ex_wnum   (ex_wnum),
        .ex_result (ex_result),
        .wb_wen    (wb_wen),
        .wb_wnum   (wb_wnum),
        .wb_data   (wb_data),
        .rs_data   (rs_data),
        .rt_data   (rt_data)
    );

    execute_unit i_execute_unit (
        .clk       (clk),
        .reset     (reset),
        .ex_valid  (ex_valid),
        .ex_pc     (ex_pc),
        .ex_op     (ex_op),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .ex_wen    (ex_wen),
        .ex_wnum   (ex_wnum),
        .ex_result (ex_result),
        .wb_pc     (debug_wb_pc),
        .wb_wen    (wb_wen),
        .wb_wnum   (wb_wnum),
        .wb_data   (wb_data)
    );

    // debug port mirrors the register file write
    assign debug_wb_rf_wen   = {4{wb_wen}};
    assign debug_wb_rf_wnum  = wb_wnum;
    assign debug_wb_rf_wdata = wb_data;

endmodule

//--- test/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef enum logic [4:0] {
    K_ADDU, K_SUBU, K_AND, K_OR, K_XOR, K_NOR, K_SLT, K_SLTU,
    K_SLL, K_SRL, K_SRA,
    K_ADDIU, K_SLTI, K_SLTIU, K_ANDI, K_ORI, K_XORI, K_LUI,
    K_BAD
} inst_kind_t;

localparam int PROG_MAX = 64;

inst_kind_t  prog_kind [PROG_MAX];
logic [4:0]  prog_rd [PROG_MAX];
logic [4:0]  prog_rs [PROG_MAX];
logic [4:0]  prog_rt [PROG_MAX];
logic [15:0] prog_imm [PROG_MAX];
word_t       prog_word [PROG_MAX];
logic        exp_wen [PROG_MAX];
logic [4:0]  exp_wnum [PROG_MAX];
word_t       exp_data [PROG_MAX];
int          prog_len = 0;
logic [31:0] lfsr = 32'h6439_a9a2;

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic logic is_rtype(input inst_kind_t kind);
    return kind inside {K_ADDU, K_SUBU, K_AND, K_OR, K_XOR, K_NOR, K_SLT, K_SLTU,
                        K_SLL, K_SRL, K_SRA};
endfunction

function automatic word_t encode_inst(input inst_kind_t kind, input logic [4:0] rd,
                                      input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [15:0] imm);
    logic [5:0] code;
    case (kind)
        K_ADDU:  code = FUNC_ADDU;
        K_SUBU:  code = FUNC_SUBU;
        K_AND:   code = FUNC_AND;
        K_OR:    code = FUNC_OR;
        K_XOR:   code = FUNC_XOR;
        K_NOR:   code = FUNC_NOR;
        K_SLT:   code = FUNC_SLT;
        K_SLTU:  code = FUNC_SLTU;
        K_SLL:   code = FUNC_SLL;
        K_SRL:   code = FUNC_SRL;
        K_SRA:   code = FUNC_SRA;
        K_ADDIU: code = OPCODE_ADDIU;
        K_SLTI:  code = OPCODE_SLTI;
        K_SLTIU: code = OPCODE_SLTIU;
        K_ANDI:  code = OPCODE_ANDI;
        K_ORI:   code = OPCODE_ORI;
        K_XORI:  code = OPCODE_XORI;
        K_LUI:   code = OPCODE_LUI;
        default: code = 6'h3f;
    endcase
    // shamt sits in the low immediate bits
    if (is_rtype(kind)) begin
        return {OPCODE_SPECIAL, rs, rt, rd, imm[4:0], code};
    end
    return {code, rs, rt, imm};
endfunction

// result by the isa rules with s from rs and t from rt
function automatic word_t model_result(input inst_kind_t kind, input word_t s,
                                       input word_t t, input logic [15:0] imm);
    word_t sext;
    word_t zext;
    sext = {{16{imm[15]}}, imm};
    zext = {16'd0, imm};
    case (kind)
        K_ADDU:  return s + t;
        K_SUBU:  return s - t;
        K_AND:   return s & t;
        K_OR:    return s | t;
        K_XOR:   return s ^ t;
        K_NOR:   return ~(s | t);
        K_SLT:   return {31'd0, $signed(s) < $signed(t)};
        K_SLTU:  return {31'd0, s < t};
        K_SLL:   return t << imm[4:0];
        K_SRL:   return t >> imm[4:0];
        K_SRA:   return $signed(t) >>> imm[4:0];
        K_ADDIU: return s + sext;
        K_SLTI:  return {31'd0, $signed(s) < $signed(sext)};
        K_SLTIU: return {31'd0, s < sext};
        K_ANDI:  return s & zext;
        K_ORI:   return s | zext;
        K_XORI:  return s ^ zext;
        K_LUI:   return {imm, 16'd0};
        default: return '0;
    endcase
endfunction

task automatic add_entry(input inst_kind_t kind, input int rd, input int rs, input int rt,
                         input int imm, input bit rnd);
    int          nbits;
    int          i;
    logic [15:0] value;
    value = 16'(imm);
    if (rnd) begin
        nbits = (kind inside {K_SLL, K_SRL, K_SRA}) ? 5 : 16;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[14:0], lfsr[0]};
        end
    end
    prog_kind[prog_len] = kind;
    prog_rd[prog_len]   = 5'(rd);
    prog_rs[prog_len]   = 5'(rs);
    prog_rt[prog_len]   = 5'(rt);
    prog_imm[prog_len]  = value;
    prog_word[prog_len] = encode_inst(kind, 5'(rd), 5'(rs), 5'(rt), value);
    prog_len++;
endtask

// columns are kind, rd, rs, rt, imm or shamt and the random imm flag
task automatic build_program();
    add_entry(K_LUI,   0,  0,  1, 0,       1);
    add_entry(K_ORI,   0,  1,  1, 0,       1);
    add_entry(K_LUI,   0,  0,  2, 0,       1);
    add_entry(K_ORI,   0,  2,  2, 0,       1);
    // r3 negative and r4 positive
    add_entry(K_LUI,   0,  0,  3, 'h8000,  0);
    add_entry(K_ORI,   0,  3,  3, 0,       1);
    add_entry(K_LUI,   0,  0,  4, 'h7fff,  0);
    add_entry(K_ADDIU, 0,  4,  4, 0,       1);
    add_entry(K_ADDU,  5,  1,  2, 0,       0);
    add_entry(K_SUBU,  6,  1,  2, 0,       0);
    add_entry(K_AND,   7,  3,  4, 0,       0);
    add_entry(K_OR,    8,  1,  3, 0,       0);
    add_entry(K_XOR,   9,  2,  4, 0,       0);
    add_entry(K_NOR,   10, 1,  2, 0,       0);
    add_entry(K_SLT,   11, 3,  4, 0,       0);
    add_entry(K_SLTU,  12, 3,  4, 0,       0);
    add_entry(K_SLL,   13, 0,  3, 0,       1);
    add_entry(K_SRL,   14, 0,  3, 0,       1);
    add_entry(K_SRA,   15, 0,  3, 0,       1);
    add_entry(K_SLTI,  0,  0,  16, 'h8000, 0);
    add_entry(K_SLTIU, 0,  4,  17, 'hffff, 0);
    add_entry(K_ANDI,  0,  3,  18, 0,      1);
    add_entry(K_XORI,  0,  4,  19, 'h8001, 0);
    add_entry(K_ADDIU, 0,  1,  20, 'h8000, 0);
    // dependent chain through EX and WB forwarding
    add_entry(K_SUBU,  21, 20, 1,  0,      0);
    add_entry(K_XOR,   22, 21, 20, 0,      0);
    add_entry(K_ADDU,  22, 22, 21, 0,      0);
    // r22 pending in both EX and WB
    add_entry(K_SUBU,  25, 22, 21, 0,      0);
    add_entry(K_ADDU,  0,  1,  2,  0,      0);
    add_entry(K_OR,    23, 0,  0,  0,      0);
    // unknown opcode aimed at r5
    add_entry(K_BAD,   0,  1,  5,  'h1234, 0);
    add_entry(K_ADDU,  24, 5,  0,  0,      0);
endtask

task automatic build_expected();
    word_t      regs [REG_COUNT];
    logic [4:0] dest;
    word_t      value;
    int         i;
    for (i = 0; i < REG_COUNT; i++) begin
        regs[i] = '0;
    end
    for (i = 0; i < prog_len; i++) begin
        dest  = is_rtype(prog_kind[i]) ? prog_rd[i] : prog_rt[i];
        value = model_result(prog_kind[i], regs[prog_rs[i]], regs[prog_rt[i]], prog_imm[i]);
        exp_wen[i]  = (prog_kind[i] != K_BAD) && (dest != 5'(LINK_FREE_ZERO_REG));
        exp_wnum[i] = dest;
        exp_data[i] = value;
        if (exp_wen[i]) begin
            regs[dest] = value;
        end
    end
endtask

`endif

//--- test/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam word_t START_PC     = 32'h0040_0100;
    localparam int    RESET_CYCLES = 10;
    localparam int    DRIVE_DELAY  = 2;
    // sample after release that sees RESET_PC presented with start set
    localparam int    FETCH_START  = 2;
    localparam int    PIPE_DEPTH   = 4;

    logic       clk;
    logic       reset;
    word_t      inst_sram_rdata;
    logic       inst_sram_en;
    word_t      inst_sram_addr;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t fetch_addr = '0;
    logic  fetch_en = 1'b0;
    int    sample_count = 0;
    int    cycle_count = 0;

    `include "tb_program.svh"

    cpu_top #(
        .RESET_PC (START_PC)
    ) i_cpu_top (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_rdata   (inst_sram_rdata),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        reset = 1'b1;
        inst_sram_rdata = '0;
        build_program();
        build_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY reset = 1'b0;
    end

    task automatic halt_run();
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_mismatch(input string field, input word_t got, input word_t want);
        $display("Fail: time %0t, %s is %h, expected %h", $time, field, got, want);
        halt_run();
    endtask

    task automatic run_problem(input string what);
        $display("%s (time %0t)", what, $time);
        halt_run();
    endtask

    // nop outside the program
    function automatic word_t word_at(input word_t addr);
        word_t offset;
        int    idx;
        offset = addr - START_PC;
        idx    = int'(offset >> 2);
        if (offset[1:0] == 2'b00 && idx < prog_len) begin
            return prog_word[idx];
        end
        return '0;
    endfunction

    // synchronous instruction memory
    always @(negedge clk) begin
        fetch_addr = inst_sram_addr;
        fetch_en   = inst_sram_en;
    end

    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (fetch_en) begin
            inst_sram_rdata = word_at(fetch_addr);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= RESET_CYCLES + prog_len + 20) begin
            run_problem("timeout: the program did not finish committing");
        end
    end

    task automatic check_commit(input int k);
        word_t want_pc;
        want_pc = START_PC + 32'(4 * k);
        assert (debug_wb_pc == want_pc) else begin
            if (debug_wb_pc - START_PC < 32'(4 * prog_len)) begin
                run_problem($sformatf("commit out of order: pc %h where %h was due",
                                      debug_wb_pc, want_pc));
            end else begin
                run_problem($sformatf("missing commit for pc %h", want_pc));
            end
        end
        assert (debug_wb_rf_wen == {4{exp_wen[k]}})
            else value_mismatch("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'({4{exp_wen[k]}}));
        if (exp_wen[k]) begin
            assert (debug_wb_rf_wnum == exp_wnum[k])
                else value_mismatch("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(exp_wnum[k]));
            assert (debug_wb_rf_wdata == exp_data[k])
                else value_mismatch("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[k]);
        end
        if (k == prog_len - 1) begin
            $display("STATUS: PASS");
            $finish;
        end
    endtask

    // commit k shows PIPE_DEPTH samples after its fetch
    always @(negedge clk) begin
        int    k;
        word_t want_addr;
        if (cycle_count > 0) begin
            if (!reset) begin
                sample_count++;
            end
            k = sample_count - (FETCH_START + PIPE_DEPTH);
            if (sample_count >= FETCH_START) begin
                want_addr = START_PC + 32'(4 * (sample_count - FETCH_START));
                assert (inst_sram_en && inst_sram_addr == want_addr)
                    else value_mismatch("inst_sram_addr", inst_sram_addr, want_addr);
            end
            if (k < 0) begin
                assert (debug_wb_rf_wen == 4'b0)
                    else value_mismatch("early debug_wb_rf_wen", 32'(debug_wb_rf_wen), '0);
            end else begin
                check_commit(k);
            end
        end
    end

endmodule

//--- mips_alu_pipe.f
+incdir+test
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/register_file.sv
logic/operand_bypass.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/cpu_top.sv
test/tb_cpu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with verilator and run, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_cpu_top -f mips_alu_pipe.f \
    && ./obj_dir/Vtb_cpu_top \
    || exit 1
